// ==== include/core_defines.svh ====
//############################
// Opcode and funct encodings,
// CSR count, bypass selects.
//############################
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Major opcodes.
`define CORE_OP_REG     7'b0110011
`define CORE_OP_IMM     7'b0010011
`define CORE_OP_LOAD    7'b0000011
`define CORE_OP_SYSTEM  7'b1110011

// Minor opcodes.
`define CORE_F3_ADD     3'b000
`define CORE_F3_XOR     3'b100
`define CORE_F3_OR      3'b110
`define CORE_F3_AND     3'b111
`define CORE_F3_LW      3'b010
`define CORE_F3_CSRRW   3'b001
`define CORE_F7_SUB     7'b0100000

// Scratch CSRs, indexed by the low address bits.
`define CORE_CSR_COUNT  4

// Operand source selects.
`define CORE_SEL_RF     2'd0
`define CORE_SEL_EM     2'd1
`define CORE_SEL_MW     2'd2

`endif

// ==== logic/core_decode.sv ====
//############################
// Decode stage: register file,
// CSR file, field decode and
// load-use hazard detection.
//############################
`timescale 1ns/1ps
`include "core_defines.svh"

module core_decode (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                instr_valid,
  input  core_pkg::instr_u    instr,
  input  logic                advance,
  input  logic                commit_valid,
  input  core_pkg::commit_t   commit,
  input  core_pkg::em_stage_t em,
  output core_pkg::de_stage_t de,
  output logic                de_start_handle,
  output logic                instr_ready
);

  logic [31:0] rf [32];
  logic [31:0] csr_file [`CORE_CSR_COUNT];
  core_pkg::de_stage_t dec;
  logic load_use;

  // Register read with the retiring write passed straight through.
  function automatic logic [31:0] rf_read(input logic [4:0] idx);
    if (idx == 5'd0) begin
      return '0;
    end
    if (commit_valid && commit.reg_write && (commit.rd == idx)) begin
      return commit.reg_data;
    end
    return rf[idx];
  endfunction

  function automatic logic [31:0] csr_read(input core_pkg::csr_idx_t idx);
    if (commit_valid && commit.csr_write && (commit.csr == idx)) begin
      return commit.csr_data;
    end
    return csr_file[idx];
  endfunction

  always_comb begin
    dec        = '0;
    dec.alu_op = core_pkg::ALU_ADD;
    case (instr.r.opcode)
      `CORE_OP_REG: begin
        dec.rs1       = instr.r.rs1;
        dec.rs2       = instr.r.rs2;
        dec.rd        = instr.r.rd;
        dec.valid     = 1'b1;
        dec.rs1_valid = 1'b1;
        dec.rs2_valid = 1'b1;
        dec.reg_write = 1'b1;
        case ({instr.r.funct7, instr.r.funct3})
          {7'd0, `CORE_F3_ADD}:         dec.alu_op = core_pkg::ALU_ADD;
          {`CORE_F7_SUB, `CORE_F3_ADD}: dec.alu_op = core_pkg::ALU_SUB;
          {7'd0, `CORE_F3_AND}:         dec.alu_op = core_pkg::ALU_AND;
          {7'd0, `CORE_F3_OR}:          dec.alu_op = core_pkg::ALU_OR;
          {7'd0, `CORE_F3_XOR}:         dec.alu_op = core_pkg::ALU_XOR;
          default:                      dec.valid  = 1'b0;
        endcase
      end
      `CORE_OP_IMM, `CORE_OP_LOAD: begin
        dec.rs1       = instr.i.rs1;
        dec.rd        = instr.i.rd;
        dec.imm       = {{20{instr.i.imm12[11]}}, instr.i.imm12};
        dec.rs1_valid = 1'b1;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        dec.is_load   = (instr.i.opcode == `CORE_OP_LOAD);
        dec.valid     = dec.is_load ? (instr.i.funct3 == `CORE_F3_LW)
                                    : (instr.i.funct3 == `CORE_F3_ADD);
      end
      `CORE_OP_SYSTEM: begin
        dec.rs1       = instr.i.rs1;
        dec.rd        = instr.i.rd;
        dec.csr       = instr.i.imm12[$bits(core_pkg::csr_idx_t)-1:0];
        dec.rs1_valid = 1'b1;
        dec.csr_valid = 1'b1;
        dec.reg_write = 1'b1;
        dec.csr_write = 1'b1;
        dec.alu_op    = core_pkg::ALU_PASS;
        dec.valid     = (instr.i.funct3 == `CORE_F3_CSRRW);
      end
      default: dec.valid = 1'b0;
    endcase
    // x0 is never a destination.
    if (dec.rd == 5'd0) begin
      dec.reg_write = 1'b0;
    end
    dec.valid    = dec.valid && instr_valid;
    dec.rs1_data = rf_read(dec.rs1);
    dec.rs2_data = rf_read(dec.rs2);
    dec.csr_data = csr_read(dec.csr);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de <= '0;
    end else if (instr_ready) begin
      de <= dec;
    end else begin
      // A waiting instruction picks up values retired meanwhile.
      de.rs1_data <= rf_read(de.rs1);
      de.rs2_data <= rf_read(de.rs2);
      de.csr_data <= csr_read(de.csr);
    end
  end

  always_ff @(posedge clk) begin
    if (commit_valid && commit.reg_write) begin
      rf[commit.rd] <= commit.reg_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CORE_CSR_COUNT; i++) begin
        csr_file[i] <= '0;
      end
    end else if (commit_valid && commit.csr_write) begin
      csr_file[commit.csr] <= commit.csr_data;
    end
  end

  // Load data is not ready until the load reaches the result stage.
  assign load_use = em.valid && em.is_load && em.reg_write &&
                    ((de.rs1_valid && (de.rs1 == em.rd)) ||
                     (de.rs2_valid && (de.rs2 == em.rd)));

  assign de_start_handle = de.valid && !load_use;
  assign instr_ready     = !de.valid || advance;

endmodule

// ==== logic/core_ex_bypass.sv ====
//############################
// Operand bypass selects and
// stage-advance permission.
//############################
`timescale 1ns/1ps
`include "core_defines.svh"

module core_ex_bypass (
  input  core_pkg::de_stage_t de,
  input  core_pkg::em_stage_t em,
  input  core_pkg::mw_stage_t mw,
  input  logic                mw_mem_data_valid,
  input  logic                de_start_handle,
  output logic [1:0]          rs1_sel,
  output logic [1:0]          rs2_sel,
  output logic [1:0]          csr_sel,
  output logic                start_handle
);

  logic rs1_em_hit;
  logic rs1_mw_hit;
  logic rs2_em_hit;
  logic rs2_mw_hit;
  logic csr_em_hit;
  logic csr_mw_hit;
  logic mw_load_wait;

  // The nearer stage wins.
  function automatic logic [1:0] pick_sel(input logic em_hit, input logic mw_hit);
    if (em_hit) begin
      return `CORE_SEL_EM;
    end
    if (mw_hit) begin
      return `CORE_SEL_MW;
    end
    return `CORE_SEL_RF;
  endfunction

  assign rs1_em_hit = de.valid && de.rs1_valid && em.valid && em.reg_write &&
                      (de.rs1 == em.rd);
  assign rs1_mw_hit = de.valid && de.rs1_valid && mw.valid && mw.reg_write &&
                      (de.rs1 == mw.rd);
  assign rs2_em_hit = de.valid && de.rs2_valid && em.valid && em.reg_write &&
                      (de.rs2 == em.rd);
  assign rs2_mw_hit = de.valid && de.rs2_valid && mw.valid && mw.reg_write &&
                      (de.rs2 == mw.rd);
  assign csr_em_hit = de.valid && de.csr_valid && em.valid && em.csr_write &&
                      (de.csr == em.csr);
  // Qualified by the result stage's own CSR write.
  assign csr_mw_hit = de.valid && de.csr_valid && mw.valid && mw.csr_write &&
                      (de.csr == mw.csr);

  assign rs1_sel = pick_sel(rs1_em_hit, rs1_mw_hit);
  assign rs2_sel = pick_sel(rs2_em_hit, rs2_mw_hit);
  assign csr_sel = pick_sel(csr_em_hit, csr_mw_hit);

  // A source taken from a load in the result stage waits for its data.
  assign mw_load_wait = mw.is_load &&
                        ((rs1_sel == `CORE_SEL_MW) || (rs2_sel == `CORE_SEL_MW));

  assign start_handle = mw_load_wait ? (de_start_handle && mw_mem_data_valid)
                                     : de_start_handle;

endmodule

// ==== logic/core_execute.sv ====
//############################
// Execute stage: operand muxes,
// ALU, CSR swap, EM register.
//############################
`timescale 1ns/1ps
`include "core_defines.svh"

module core_execute (
  input  logic                clk,
  input  logic                rst_n,
  input  core_pkg::de_stage_t de,
  input  logic [1:0]          rs1_sel,
  input  logic [1:0]          rs2_sel,
  input  logic [1:0]          csr_sel,
  input  logic                start_handle,
  input  logic                mw_stall,
  input  core_pkg::mw_stage_t mw,
  input  logic [31:0]         mw_fwd_data,
  output logic                advance,
  output core_pkg::em_stage_t em
);

  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] csr_val;
  logic [31:0] op_b;
  logic [31:0] alu_out;
  core_pkg::em_stage_t em_next;

  function automatic logic [31:0] pick(input logic [1:0] sel, input logic [31:0] rf_val,
                                       input logic [31:0] em_val, input logic [31:0] mw_val);
    case (sel)
      `CORE_SEL_EM: return em_val;
      `CORE_SEL_MW: return mw_val;
      default:      return rf_val;
    endcase
  endfunction

  assign rs1_val = pick(rs1_sel, de.rs1_data, em.result, mw_fwd_data);
  assign rs2_val = pick(rs2_sel, de.rs2_data, em.result, mw_fwd_data);
  assign csr_val = pick(csr_sel, de.csr_data, em.csr_result, mw.csr_result);
  assign op_b    = de.use_imm ? de.imm : rs2_val;

  always_comb begin
    case (de.alu_op)
      core_pkg::ALU_SUB:  alu_out = rs1_val - op_b;
      core_pkg::ALU_AND:  alu_out = rs1_val & op_b;
      core_pkg::ALU_OR:   alu_out = rs1_val | op_b;
      core_pkg::ALU_XOR:  alu_out = rs1_val ^ op_b;
      // CSRRW hands the old CSR value to rd.
      core_pkg::ALU_PASS: alu_out = csr_val;
      default:            alu_out = rs1_val + op_b;
    endcase
  end

  always_comb begin
    em_next.valid      = de.valid;
    em_next.rd         = de.rd;
    em_next.reg_write  = de.reg_write;
    em_next.csr        = de.csr;
    em_next.csr_write  = de.csr_write;
    em_next.is_load    = de.is_load;
    em_next.result     = alu_out;
    em_next.csr_result = rs1_val;
  end

  assign advance = start_handle && !mw_stall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      em <= '0;
    end else if (!mw_stall) begin
      if (advance) begin
        em <= em_next;
      end else begin
        // Bubble while decode cannot start.
        em.valid <= 1'b0;
      end
    end
  end

endmodule

// ==== logic/core_pkg.sv ====
//############################
// Instruction union, ALU ops
// and pipeline stage records.
//############################
`include "core_defines.svh"

package core_pkg;

  typedef logic [$clog2(`CORE_CSR_COUNT)-1:0] csr_idx_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  // For CSRRW the immediate carries the CSR address.
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS
  } alu_op_e;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rs1;
    logic        rs1_valid;
    logic [4:0]  rs2;
    logic        rs2_valid;
    csr_idx_t    csr;
    logic        csr_valid;
    logic [4:0]  rd;
    logic        reg_write;
    logic        csr_write;
    logic        is_load;
    logic        use_imm;
    alu_op_e     alu_op;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] csr_data;
  } de_stage_t;

  // Result holds the ALU value, or the address for a load.
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic        reg_write;
    csr_idx_t    csr;
    logic        csr_write;
    logic        is_load;
    logic [31:0] result;
    logic [31:0] csr_result;
  } em_stage_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic        reg_write;
    csr_idx_t    csr;
    logic        csr_write;
    logic        is_load;
    logic [31:0] result;
    logic [31:0] csr_result;
    logic        req_sent;
  } mw_stage_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic        reg_write;
    logic [31:0] reg_data;
    csr_idx_t    csr;
    logic        csr_write;
    logic [31:0] csr_data;
  } commit_t;

endpackage

// ==== logic/core_result.sv ====
//############################
// Result stage: memory request,
// load wait and commit.
//############################
`timescale 1ns/1ps

module core_result (
  input  logic                clk,
  input  logic                rst_n,
  input  core_pkg::em_stage_t em,
  input  logic                mem_rdata_valid,
  input  logic [31:0]         mem_rdata,
  output core_pkg::mw_stage_t mw,
  output logic [31:0]         mw_fwd_data,
  output logic                mw_stall,
  output logic                mw_mem_data_valid,
  output logic                mem_req_valid,
  output logic [31:0]         mem_addr,
  output logic                commit_valid,
  output core_pkg::commit_t   commit
);

  // One request per load, in its first cycle here.
  assign mem_req_valid     = mw.valid && mw.is_load && !mw.req_sent;
  assign mem_addr          = mw.result;
  assign mw_mem_data_valid = mw.valid && mw.is_load && mem_rdata_valid;
  assign mw_stall          = mw.valid && mw.is_load && !mem_rdata_valid;
  assign mw_fwd_data       = mw.is_load ? mem_rdata : mw.result;

  assign commit_valid = mw.valid && !mw_stall;

  always_comb begin
    commit.rd        = mw.rd;
    commit.reg_write = mw.reg_write;
    commit.reg_data  = mw_fwd_data;
    commit.csr       = mw.csr;
    commit.csr_write = mw.csr_write;
    commit.csr_data  = mw.csr_result;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mw <= '0;
    end else if (!mw_stall) begin
      mw.valid      <= em.valid;
      mw.rd         <= em.rd;
      mw.reg_write  <= em.reg_write;
      mw.csr        <= em.csr;
      mw.csr_write  <= em.csr_write;
      mw.is_load    <= em.is_load;
      mw.result     <= em.result;
      mw.csr_result <= em.csr_result;
      mw.req_sent   <= 1'b0;
    end else begin
      mw.req_sent <= 1'b1;
    end
  end

endmodule

// ==== logic/core_top.sv ====
//############################
// Core top: decode, bypass,
// execute and result stages.
//############################
`timescale 1ns/1ps

module core_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid,
  input  core_pkg::instr_u  instr,
  input  logic              mem_rdata_valid,
  input  logic [31:0]       mem_rdata,
  output logic              instr_ready,
  output logic              mem_req_valid,
  output logic [31:0]       mem_addr,
  output logic              commit_valid,
  output core_pkg::commit_t commit
);

  core_pkg::de_stage_t de;
  core_pkg::em_stage_t em;
  core_pkg::mw_stage_t mw;
  logic                de_start_handle;
  logic                start_handle;
  logic                advance;
  logic                mw_stall;
  logic                mw_mem_data_valid;
  logic [31:0]         mw_fwd_data;
  logic [1:0]          rs1_sel;
  logic [1:0]          rs2_sel;
  logic [1:0]          csr_sel;

  core_decode u_decode (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_valid     (instr_valid),
    .instr           (instr),
    .advance         (advance),
    .commit_valid    (commit_valid),
    .commit          (commit),
    .em              (em),
    .de              (de),
    .de_start_handle (de_start_handle),
    .instr_ready     (instr_ready)
  );

  core_ex_bypass u_bypass (
    .de                (de),
    .em                (em),
    .mw                (mw),
    .mw_mem_data_valid (mw_mem_data_valid),
    .de_start_handle   (de_start_handle),
    .rs1_sel           (rs1_sel),
    .rs2_sel           (rs2_sel),
    .csr_sel           (csr_sel),
    .start_handle      (start_handle)
  );

  core_execute u_execute (
    .clk          (clk),
    .rst_n        (rst_n),
    .de           (de),
    .rs1_sel      (rs1_sel),
    .rs2_sel      (rs2_sel),
    .csr_sel      (csr_sel),
    .start_handle (start_handle),
    .mw_stall     (mw_stall),
    .mw           (mw),
    .mw_fwd_data  (mw_fwd_data),
    .advance      (advance),
    .em           (em)
  );

  core_result u_result (
    .clk               (clk),
    .rst_n             (rst_n),
    .em                (em),
    .mem_rdata_valid   (mem_rdata_valid),
    .mem_rdata         (mem_rdata),
    .mw                (mw),
    .mw_fwd_data       (mw_fwd_data),
    .mw_stall          (mw_stall),
    .mw_mem_data_valid (mw_mem_data_valid),
    .mem_req_valid     (mem_req_valid),
    .mem_addr          (mem_addr),
    .commit_valid      (commit_valid),
    .commit            (commit)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Compiles the core testbench with Verilator and runs it.
# The exit status of the simulation is the exit status of this script.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module core_tb \
  -f verilog.f \
  -o core_tb_sim

./obj_dir/core_tb_sim

// ==== sim/core_asserts.sv ====
//############################
// Concurrent assertions bound
// to core_top.
//############################
`timescale 1ns/1ps

module core_asserts (
  input logic              clk,
  input logic              rst_n,
  input logic              instr_ready,
  input logic              mem_req_valid,
  input logic              mem_rdata_valid,
  input logic              commit_valid,
  input core_pkg::commit_t commit
);

  logic load_outstanding;

  // Set by a request, cleared by the data pulse.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_outstanding <= 1'b0;
    end else if (mem_req_valid) begin
      load_outstanding <= 1'b1;
    end else if (mem_rdata_valid) begin
      load_outstanding <= 1'b0;
    end
  end

  a_single_request: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid |-> !load_outstanding)
    else $error("memory request issued while a load is outstanding");

  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    commit_valid |-> !(commit.reg_write && (commit.rd == 5'd0)))
    else $error("commit writes register x0");

  a_ready_in_reset: assert property (@(posedge clk)
    !rst_n |-> instr_ready)
    else $error("instr_ready low during reset");

endmodule

bind core_top core_asserts u_asserts (
  .clk             (clk),
  .rst_n           (rst_n),
  .instr_ready     (instr_ready),
  .mem_req_valid   (mem_req_valid),
  .mem_rdata_valid (mem_rdata_valid),
  .commit_valid    (commit_valid),
  .commit          (commit)
);

// ==== sim/core_tb.sv ====
//############################
// Testbench for core_top with
// instruction table, memory
// model, LCG and commit checks.
//############################
`timescale 1ns/1ps
`include "core_defines.svh"

module core_tb;

  typedef struct packed {
    logic [31:0]        instr;
    logic               commits;
    logic [4:0]         rd;
    logic               reg_write;
    logic [31:0]        reg_data;
    core_pkg::csr_idx_t csr;
    logic               csr_write;
    logic [31:0]        csr_data;
  } entry_t;

  logic              clk;
  logic              rst_n;
  logic              instr_valid;
  core_pkg::instr_u  instr;
  logic              mem_rdata_valid;
  logic [31:0]       mem_rdata;
  logic              instr_ready;
  logic              mem_req_valid;
  logic [31:0]       mem_addr;
  logic              commit_valid;
  core_pkg::commit_t commit;

  entry_t      tbl[$];
  int          expect_q[$];
  logic [31:0] lcg_state;

  core_tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  core_top u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_valid     (instr_valid),
    .instr           (instr),
    .mem_rdata_valid (mem_rdata_valid),
    .mem_rdata       (mem_rdata),
    .instr_ready     (instr_ready),
    .mem_req_valid   (mem_req_valid),
    .mem_addr        (mem_addr),
    .commit_valid    (commit_valid),
    .commit          (commit)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Instruction encoders.
  function automatic logic [31:0] alu(input logic [6:0] f7, input logic [2:0] f3,
                                      input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `CORE_OP_REG};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], `CORE_F3_ADD, rd[4:0], `CORE_OP_IMM};
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], `CORE_F3_LW, rd[4:0], `CORE_OP_LOAD};
  endfunction

  function automatic logic [31:0] csrrw(input int rd, input int csr, input int rs1);
    return {csr[11:0], rs1[4:0], `CORE_F3_CSRRW, rd[4:0], `CORE_OP_SYSTEM};
  endfunction

  // A destination of x0 is never written.
  function automatic entry_t reg_row(input logic [31:0] word, input int rd,
                                     input logic [31:0] value);
    entry_t e;
    e           = '0;
    e.instr     = word;
    e.commits   = 1'b1;
    e.rd        = rd[4:0];
    e.reg_write = (rd != 0);
    e.reg_data  = value;
    return e;
  endfunction

  function automatic entry_t csr_row(input logic [31:0] word, input int rd,
                                     input logic [31:0] value,
                                     input core_pkg::csr_idx_t csr,
                                     input logic [31:0] csr_value);
    entry_t e;
    e           = reg_row(word, rd, value);
    e.csr       = csr;
    e.csr_write = 1'b1;
    e.csr_data  = csr_value;
    return e;
  endfunction

  function automatic entry_t none_row(input logic [31:0] word);
    entry_t e;
    e       = '0;
    e.instr = word;
    return e;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
    if (got !== expected) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      $display("CHECKS FAILED");
      $fatal(1, "first mismatch ends the run");
    end
  endtask

  task automatic check_commit();
    entry_t e;
    int     n;
    if (expect_q.size() == 0) begin
      $display("Commit at %0t ns with no instruction left to retire", $time);
      $display("CHECKS FAILED");
      $fatal(1, "unexpected commit");
    end
    n = expect_q.pop_front();
    e = tbl[n];
    compare_value($sformatf("entry %0d rd", n), 32'(commit.rd), 32'(e.rd));
    compare_value($sformatf("entry %0d reg_write", n), 32'(commit.reg_write),
                  32'(e.reg_write));
    if (e.reg_write) begin
      compare_value($sformatf("entry %0d reg_data", n), commit.reg_data, e.reg_data);
    end
    compare_value($sformatf("entry %0d csr_write", n), 32'(commit.csr_write),
                  32'(e.csr_write));
    if (e.csr_write) begin
      compare_value($sformatf("entry %0d csr", n), 32'(commit.csr), 32'(e.csr));
      compare_value($sformatf("entry %0d csr_data", n), commit.csr_data, e.csr_data);
    end
  endtask

  task automatic build_table();
    // Independent ALU and ADDI results.
    tbl.push_back(reg_row(addi(1, 0, 'h123), 1, 32'h0000_0123));
    tbl.push_back(reg_row(addi(2, 0, 'h456), 2, 32'h0000_0456));
    tbl.push_back(reg_row(addi(3, 0, -1), 3, 32'hffff_ffff));
    tbl.push_back(reg_row(alu(7'd0, `CORE_F3_ADD, 4, 1, 2), 4, 32'h0000_0579));
    tbl.push_back(reg_row(alu(`CORE_F7_SUB, `CORE_F3_ADD, 5, 2, 1), 5, 32'h0000_0333));
    tbl.push_back(reg_row(alu(7'd0, `CORE_F3_AND, 6, 3, 2), 6, 32'h0000_0456));
    tbl.push_back(reg_row(alu(7'd0, `CORE_F3_OR, 7, 1, 2), 7, 32'h0000_0577));
    // Distance-one chain through the EM stage.
    tbl.push_back(reg_row(addi(9, 1, 1), 9, 32'h0000_0124));
    tbl.push_back(reg_row(alu(7'd0, `CORE_F3_ADD, 9, 9, 9), 9, 32'h0000_0248));
    tbl.push_back(reg_row(alu(7'd0, `CORE_F3_ADD, 9, 9, 1), 9, 32'h0000_036b));
    // Distance-two chain through the result stage.
    tbl.push_back(reg_row(addi(10, 0, 'h10), 10, 32'h0000_0010));
    tbl.push_back(reg_row(addi(11, 0, 'h20), 11, 32'h0000_0020));
    tbl.push_back(reg_row(alu(7'd0, `CORE_F3_ADD, 10, 10, 11), 10, 32'h0000_0030));
    tbl.push_back(reg_row(addi(12, 0, 7), 12, 32'h0000_0007));
    tbl.push_back(reg_row(alu(`CORE_F7_SUB, `CORE_F3_ADD, 13, 10, 12), 13, 32'h0000_0029));
    // Loads return the address XOR 5a5a0000.
    tbl.push_back(reg_row(addi(14, 0, 'h100), 14, 32'h0000_0100));
    tbl.push_back(reg_row(lw(15, 14, 'h40), 15, 32'h5a5a_0140));
    tbl.push_back(reg_row(alu(7'd0, `CORE_F3_ADD, 16, 15, 1), 16, 32'h5a5a_0263));
    tbl.push_back(reg_row(lw(17, 14, -4), 17, 32'h5a5a_00fc));
    tbl.push_back(reg_row(addi(18, 17, 4), 18, 32'h5a5a_0100));
    tbl.push_back(reg_row(lw(19, 0, 8), 19, 32'h5a5a_0008));
    tbl.push_back(reg_row(addi(20, 0, 1), 20, 32'h0000_0001));
    tbl.push_back(reg_row(alu(7'd0, `CORE_F3_XOR, 21, 19, 20), 21, 32'h5a5a_0009));
    // CSR swaps through both forwarding paths.
    tbl.push_back(csr_row(csrrw(22, 1, 5), 22, 32'h0000_0000, 2'd1, 32'h0000_0333));
    tbl.push_back(csr_row(csrrw(23, 1, 6), 23, 32'h0000_0333, 2'd1, 32'h0000_0456));
    tbl.push_back(csr_row(csrrw(24, 2, 7), 24, 32'h0000_0000, 2'd2, 32'h0000_0577));
    tbl.push_back(reg_row(addi(0, 1, 5), 0, 32'h0000_0000));
    tbl.push_back(csr_row(csrrw(25, 2, 1), 25, 32'h0000_0577, 2'd2, 32'h0000_0123));
    tbl.push_back(reg_row(alu(7'd0, `CORE_F3_ADD, 26, 0, 1), 26, 32'h0000_0123));
    // Unknown opcode.
    tbl.push_back(none_row(32'h0000_0000));
    // Both CSRs end at zero for the next pass.
    tbl.push_back(csr_row(csrrw(27, 1, 0), 27, 32'h0000_0456, 2'd1, 32'h0000_0000));
    tbl.push_back(csr_row(csrrw(0, 2, 0), 0, 32'h0000_0000, 2'd2, 32'h0000_0000));
    tbl.push_back(reg_row(alu(7'd0, `CORE_F3_ADD, 28, 23, 25), 28, 32'h0000_08aa));
    // A result stage without a CSR write forwards no CSR value.
    tbl.push_back(reg_row(addi(29, 28, 1), 29, 32'h0000_08ab));
    tbl.push_back(csr_row(csrrw(30, 0, 2), 30, 32'h0000_0000, 2'd0, 32'h0000_0456));
    tbl.push_back(csr_row(csrrw(31, 0, 0), 31, 32'h0000_0456, 2'd0, 32'h0000_0000));
  endtask

  initial begin
    int          idx;
    int          mem_wait;
    int          cycles;
    int          limit;
    logic        presenting;
    logic [31:0] rnd;
    logic [31:0] req_addr;
    instr_valid     = 1'b0;
    instr           = '0;
    mem_rdata_valid = 1'b0;
    mem_rdata       = '0;
    lcg_state       = 32'h79ba6c34;
    mem_wait        = 0;
    cycles          = 0;
    req_addr        = '0;
    build_table();
    limit = 12 * tbl.size() * 2;
    wait (rst_n === 1'b1);

    // Pass 0 keeps instr_valid high, pass 1 leaves random idle gaps.
    for (int pass = 0; pass < 2; pass++) begin
      idx        = 0;
      presenting = 1'b0;
      while ((idx < tbl.size()) || (expect_q.size() != 0)) begin
        @(negedge clk);
        cycles++;
        if (cycles > limit) begin
          $display("Timeout after %0d cycles with %0d of %0d entries issued in pass %0d",
                   cycles, idx, tbl.size(), pass);
          $display("CHECKS FAILED");
          $fatal(1, "run did not finish in time");
        end
        mem_rdata_valid = 1'b0;
        if (mem_wait > 0) begin
          mem_wait--;
          if (mem_wait == 0) begin
            mem_rdata_valid = 1'b1;
            mem_rdata       = req_addr ^ 32'h5a5a0000;
          end
        end
        if (!presenting && (idx < tbl.size())) begin
          rnd        = lcg_next();
          presenting = (pass == 0) || (rnd[17:16] != 2'b00);
        end
        instr_valid = presenting;
        if (presenting) begin
          instr = tbl[idx].instr;
        end else begin
          instr = '0;
        end
        // Outputs are settled well before the next rising edge.
        #1;
        if (commit_valid) begin
          check_commit();
        end
        if (mem_req_valid) begin
          rnd      = lcg_next();
          mem_wait = 1 + int'(rnd[17:16]);
          req_addr = mem_addr;
        end
        if (instr_valid && instr_ready) begin
          if (tbl[idx].commits) begin
            expect_q.push_back(idx);
          end
          idx++;
          presenting = 1'b0;
        end
      end
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== sim/core_tb_clock.sv ====
//############################
// Testbench clock (10 ns) and
// reset, low for 2 cycles.
//############################
`timescale 1ns/1ps

module core_tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release on a falling edge, away from the active clock edge.
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== verilog.f ====
+incdir+include
logic/core_pkg.sv
logic/core_decode.sv
logic/core_ex_bypass.sv
logic/core_execute.sv
logic/core_result.sv
logic/core_top.sv
sim/core_tb_clock.sv
sim/core_asserts.sv
sim/core_tb.sv
